// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    // default geometry, overridden through the top level parameters
    parameter int DEF_INDEX_WIDTH       = 6;
    parameter int DEF_WORD_OFFSET_WIDTH = 4;

    localparam int LINE_BITS  = 32 << DEF_WORD_OFFSET_WIDTH;  // 512
    localparam int LINE_WORDS = LINE_BITS / 32;
    localparam int LINE_BYTES = LINE_BITS / 8;
    localparam int TAG_WIDTH  = 32 - DEF_INDEX_WIDTH - DEF_WORD_OFFSET_WIDTH - 2;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    // one cache line, read by word or written by byte
    typedef union packed {
        logic [LINE_WORDS-1:0][31:0] w;
        logic [LINE_BYTES-1:0][7:0]  b;
    } line_u;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        LOOKUP    = 4'd1,
        WRITEBACK = 4'd2,
        MISS      = 4'd3,
        REFILL    = 4'd4,
        RESPOND   = 4'd5
    } ctrl_state_e;

endpackage

// ==== hw/dcache_ifs.sv ====
interface req_if import dcache_pkg::*; #(
    parameter int INDEX_WIDTH       = DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = DEF_WORD_OFFSET_WIDTH
);
    logic [31:0]                  addr;
    logic [TAG_WIDTH-1:0]         tag;
    logic [INDEX_WIDTH-1:0]       index;
    logic [WORD_OFFSET_WIDTH-1:0] word;
    line_u                        wline;  // store data on its lanes
    logic [LINE_BYTES-1:0]        bmask;  // zero for loads
    logic                         op;     // 1 = store
    size_e                        size;
    logic                         sgn;
    logic                         ale;

    modport stage (output addr, tag, index, word, wline, bmask, op, size, sgn, ale);
    modport ctrl  (input op, ale);
    modport ways  (input tag, index, wline, bmask);
    modport port  (input tag, index);
endinterface

interface way_if import dcache_pkg::*;;
    logic                 hit, hit_way, victim_way, victim_dirty;
    logic [TAG_WIDTH-1:0] victim_tag;
    line_u                hit_line, victim_line;
    logic                 data_we, we_way, fill_sel, tag_we;
    logic                 dirty_we, dirty_val, lru_we;

    modport ways (output hit, hit_way, victim_way, victim_dirty, victim_tag, hit_line,
                  victim_line, input data_we, we_way, fill_sel, tag_we, dirty_we,
                  dirty_val, lru_we);
    modport ctrl (input hit, hit_way, victim_way, victim_dirty, output data_we, we_way,
                  fill_sel, tag_we, dirty_we, dirty_val, lru_we);
    modport port (input victim_tag, victim_line);
endinterface

interface fill_if import dcache_pkg::*;;
    line_u refill_line;
    logic  rd_done, wr_done;
    logic  wb_start, rd_start;

    modport port (output refill_line, rd_done, wr_done, input wb_start, rd_start);
    modport ctrl (input rd_done, wr_done, output wb_start, rd_start);
    modport ways (input refill_line);
endinterface

// ==== hw/dcache_ctrl.sv ====
module dcache_ctrl import dcache_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic i_valid,
    output logic o_idle,
    output logic o_done,
    output logic o_from_fill,   // load data comes from the refill buffer
    output logic o_mem_rvalid,
    output logic o_mem_wvalid,
    req_if.ctrl  r,
    way_if.ctrl  w,
    fill_if.ctrl f
);
    ctrl_state_e state, next_state;

    assign o_idle      = (state == IDLE);
    assign o_from_fill = (state == RESPOND);

    always_comb begin
        next_state  = state;
        o_done      = 1'b0;
        w.data_we   = 1'b0;
        w.we_way    = w.hit_way;
        w.fill_sel  = 1'b0;
        w.tag_we    = 1'b0;
        w.dirty_we  = 1'b0;
        w.dirty_val = 1'b0;
        w.lru_we    = 1'b0;
        f.wb_start  = 1'b0;
        f.rd_start  = 1'b0;
        case (state)
            IDLE: if (i_valid) next_state = LOOKUP;
            LOOKUP: begin
                if (r.ale) begin
                    o_done     = 1'b1;  // error, nothing touched
                    next_state = IDLE;
                end else if (w.hit) begin
                    o_done     = 1'b1;
                    w.lru_we   = 1'b1;
                    next_state = IDLE;
                    if (r.op) begin
                        w.data_we   = 1'b1;  // store into hit way under mask
                        w.dirty_we  = 1'b1;
                        w.dirty_val = 1'b1;
                    end
                end else if (w.victim_dirty) begin
                    f.wb_start = 1'b1;
                    next_state = WRITEBACK;
                end else begin
                    f.rd_start = 1'b1;
                    next_state = MISS;
                end
            end
            WRITEBACK: begin
                if (f.wr_done) begin
                    f.rd_start = 1'b1;  // refill right behind the writeback
                    next_state = MISS;
                end
            end
            MISS: if (f.rd_done) next_state = REFILL;
            REFILL: begin
                w.we_way    = w.victim_way;
                w.data_we   = 1'b1;
                w.fill_sel  = 1'b1;
                w.tag_we    = 1'b1;
                w.dirty_we  = 1'b1;
                w.dirty_val = r.op;     // dirty only when the store merged in
                w.lru_we    = 1'b1;
                next_state  = RESPOND;
            end
            RESPOND: begin
                o_done     = 1'b1;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= IDLE;
            o_mem_rvalid <= 1'b0;
            o_mem_wvalid <= 1'b0;
        end else begin
            state <= next_state;
            // valids held until the transfer cycle
            if (f.wb_start) begin
                o_mem_wvalid <= 1'b1;
            end else if (f.wr_done) begin
                o_mem_wvalid <= 1'b0;
            end
            if (f.rd_start) begin
                o_mem_rvalid <= 1'b1;
            end else if (f.rd_done) begin
                o_mem_rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/dcache_req_stage.sv ====
module dcache_req_stage import dcache_pkg::*; #(
    parameter int INDEX_WIDTH       = DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = DEF_WORD_OFFSET_WIDTH
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_accept,
    input  logic        i_op,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_wdata,
    input  size_e       i_size,
    input  logic        i_signed,
    input  logic        i_from_fill,
    input  line_u       i_hit_line,
    input  line_u       i_fill_line,
    output logic [31:0] o_rdata,
    output logic        o_ale,
    req_if.stage        r
);
    logic [31:0] wdata_q;
    logic [31:0] lane_data;  // store data copied to every lane
    logic [3:0]  lanes;
    line_u       src;
    logic [31:0] word_d;
    logic [7:0]  byte_d;
    logic [15:0] half_d;

    always_ff @(posedge clk) begin
        if (i_accept) begin
            r.addr  <= i_addr;
            wdata_q <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r.op   <= 1'b0;
            r.size <= SZ_WORD;
            r.sgn  <= 1'b0;
        end else if (i_accept) begin
            r.op   <= i_op;
            r.size <= i_size;
            r.sgn  <= i_signed;
        end
    end

    assign r.tag   = r.addr[31 -: TAG_WIDTH];
    assign r.index = r.addr[WORD_OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign r.word  = r.addr[2 +: WORD_OFFSET_WIDTH];
    assign r.ale   = ((r.size == SZ_HALF) && r.addr[0]) ||
                     ((r.size == SZ_WORD) && (r.addr[1:0] != 2'b00));
    assign o_ale   = r.ale;

    always_comb begin
        case (r.size)
            SZ_BYTE: begin
                lanes     = 4'b0001 << r.addr[1:0];
                lane_data = {4{wdata_q[7:0]}};
            end
            SZ_HALF: begin
                lanes     = 4'b0011 << r.addr[1:0];
                lane_data = {2{wdata_q[15:0]}};
            end
            default: begin
                lanes     = 4'b1111;
                lane_data = wdata_q;
            end
        endcase
        for (int i = 0; i < LINE_BYTES; i++) begin
            r.wline.b[i] = lane_data[8*(i%4) +: 8];
        end
        r.bmask = r.op ? ({{(LINE_BYTES-4){1'b0}}, lanes} << {r.word, 2'b00}) : '0;
    end

    // load path, sign or zero extended
    always_comb begin
        src    = i_from_fill ? i_fill_line : i_hit_line;
        word_d = src.w[r.word];
        byte_d = word_d[{r.addr[1:0], 3'b000} +: 8];
        half_d = r.addr[1] ? word_d[31:16] : word_d[15:0];
        case (r.size)
            SZ_BYTE: o_rdata = {{24{r.sgn & byte_d[7]}}, byte_d};
            SZ_HALF: o_rdata = {{16{r.sgn & half_d[15]}}, half_d};
            default: o_rdata = word_d;
        endcase
    end

endmodule

// ==== hw/dcache_ways.sv ====
module dcache_ways import dcache_pkg::*; #(
    parameter int INDEX_WIDTH       = DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = DEF_WORD_OFFSET_WIDTH
) (
    input  logic clk,
    input  logic rstn,
    req_if.ways  r,
    way_if.ways  w,
    fill_if.ways f
);
    localparam int SETS = 1 << INDEX_WIDTH;

    line_u                data_q [2][SETS];
    logic [TAG_WIDTH-1:0] tag_q  [2][SETS];
    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]      lru_q;     // names the least recently used way
    logic [1:0]           way_hit;
    line_u                base;
    line_u                new_line;

    assign way_hit[0] = valid_q[0][r.index] && (tag_q[0][r.index] == r.tag);
    assign way_hit[1] = valid_q[1][r.index] && (tag_q[1][r.index] == r.tag);
    assign w.hit      = |way_hit;
    assign w.hit_way  = way_hit[1];
    assign w.hit_line = data_q[w.hit_way][r.index];

    // an empty way goes first, else the lru one
    assign w.victim_way   = !valid_q[0][r.index] ? 1'b0 :
                            !valid_q[1][r.index] ? 1'b1 : lru_q[r.index];
    assign w.victim_dirty = valid_q[w.victim_way][r.index] & dirty_q[w.victim_way][r.index];
    assign w.victim_tag   = tag_q[w.victim_way][r.index];
    assign w.victim_line  = data_q[w.victim_way][r.index];

    // merge store bytes over the refill or the current line
    always_comb begin
        base = w.fill_sel ? f.refill_line : data_q[w.we_way][r.index];
        for (int i = 0; i < LINE_BYTES; i++) begin
            new_line.b[i] = r.bmask[i] ? r.wline.b[i] : base.b[i];
        end
    end

    always_ff @(posedge clk) begin
        if (w.data_we) begin
            data_q[w.we_way][r.index] <= new_line;
        end
        if (w.tag_we) begin
            tag_q[w.we_way][r.index] <= r.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (w.tag_we) begin
                valid_q[w.we_way][r.index] <= 1'b1;
            end
            if (w.dirty_we) begin
                dirty_q[w.we_way][r.index] <= w.dirty_val;
            end
            if (w.lru_we) begin
                lru_q[r.index] <= ~w.we_way;  // other way now oldest
            end
        end
    end

endmodule

// ==== hw/dcache_mem_port.sv ====
module dcache_mem_port import dcache_pkg::*; #(
    parameter int INDEX_WIDTH       = DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = DEF_WORD_OFFSET_WIDTH
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 o_mem_rvalid,
    input  logic                 i_mem_rready,
    input  logic [LINE_BITS-1:0] i_mem_rdata,
    input  logic                 o_mem_wvalid,
    input  logic                 i_mem_wready,
    output logic [31:0]          o_mem_raddr,
    output logic [31:0]          o_mem_waddr,
    output logic [LINE_BITS-1:0] o_mem_wdata,
    fill_if.port                 f,
    req_if.port                  r,
    way_if.port                  w
);
    localparam int OFF_BITS = WORD_OFFSET_WIDTH + 2;

    line_u wbuf_q;  // victim line under writeback
    line_u fill_q;

    assign f.rd_done     = o_mem_rvalid & i_mem_rready;
    assign f.wr_done     = o_mem_wvalid & i_mem_wready;
    assign f.refill_line = fill_q;
    assign o_mem_wdata   = wbuf_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mem_raddr <= '0;
            o_mem_waddr <= '0;
        end else begin
            if (f.rd_start) begin
                o_mem_raddr <= {r.tag, r.index, {OFF_BITS{1'b0}}};  // line aligned
            end
            if (f.wb_start) begin
                o_mem_waddr <= {w.victim_tag, r.index, {OFF_BITS{1'b0}}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (f.wb_start) begin
            wbuf_q <= w.victim_line;
        end
        if (f.rd_done) begin
            fill_q <= i_mem_rdata;
        end
    end

endmodule

// ==== hw/dcache_top.sv ====
module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_WIDTH       = DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = DEF_WORD_OFFSET_WIDTH
) (
    input  logic                 clk,
    input  logic                 rstn,
    // pipeline side
    input  logic                 i_valid,
    input  logic                 i_op,
    input  logic [31:0]          i_addr,
    input  logic [31:0]          i_wdata,
    input  size_e                i_size,
    input  logic                 i_signed,
    output logic                 o_idle,
    output logic                 o_done,
    output logic [31:0]          o_rdata,
    output logic                 o_ale,
    // memory side
    output logic                 o_mem_rvalid,
    input  logic                 i_mem_rready,
    output logic [31:0]          o_mem_raddr,
    input  logic [LINE_BITS-1:0] i_mem_rdata,
    output logic                 o_mem_wvalid,
    input  logic                 i_mem_wready,
    output logic [31:0]          o_mem_waddr,
    output logic [LINE_BITS-1:0] o_mem_wdata
);
    logic accept;
    logic from_fill;

    req_if #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_req ();
    way_if  u_way ();
    fill_if u_fill ();

    assign accept = o_idle & i_valid;

    dcache_ctrl u_ctrl (
        .clk, .rstn, .i_valid, .o_idle, .o_done, .o_from_fill(from_fill),
        .o_mem_rvalid, .o_mem_wvalid, .r(u_req), .w(u_way), .f(u_fill)
    );

    dcache_req_stage #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_stage (
        .clk, .rstn, .i_accept(accept), .i_op, .i_addr, .i_wdata, .i_size, .i_signed,
        .i_from_fill(from_fill), .i_hit_line(u_way.hit_line),
        .i_fill_line(u_fill.refill_line), .o_rdata, .o_ale, .r(u_req)
    );

    dcache_ways #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_ways (
        .clk, .rstn, .r(u_req), .w(u_way), .f(u_fill)
    );

    dcache_mem_port #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_mem (
        .clk, .rstn, .o_mem_rvalid, .i_mem_rready, .i_mem_rdata, .o_mem_wvalid,
        .i_mem_wready, .o_mem_raddr, .o_mem_waddr, .o_mem_wdata,
        .f(u_fill), .r(u_req), .w(u_way)
    );

endmodule

// ==== test/tb_mem_model.sv ====
module tb_mem_model import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_rvalid,
    output logic                 o_rready,
    input  logic [31:0]          i_raddr,
    output logic [LINE_BITS-1:0] o_rdata,
    input  logic                 i_wvalid,
    output logic                 o_wready,
    input  logic [31:0]          i_waddr,
    input  logic [LINE_BITS-1:0] i_wdata,
    input  logic [LINE_BITS-1:0] i_wb_expect,  // shadow copy of the line at i_waddr
    output logic                 o_err
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [LINE_BITS-1:0] lines [logic [31:0]];  // only lines written back
    logic [1:0]           rdelay;
    logic [1:0]           wdelay;
    integer               seed = 32'h88fe0043;

    // untouched memory holds the word address with its upper half inverted
    function automatic logic [LINE_BITS-1:0] fetch_line(input logic [31:0] addr);
        line_u       l;
        logic [31:0] a;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int i = 0; i < LINE_WORDS; i++) begin
            a      = addr + 32'(4 * i);
            l.w[i] = {~a[31:16], a[15:0]};
        end
        return l;
    endfunction

    initial begin
        o_rready = 1'b0;
        o_wready = 1'b0;
        o_rdata  = '0;
        o_err    = 1'b0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            o_rready <= 1'b0;
            o_wready <= 1'b0;
            o_err    <= 1'b0;
            rdelay   <= 2'($unsigned($random(seed)) % 4);
            wdelay   <= 2'($unsigned($random(seed)) % 4);
        end else begin
            if (o_rready) begin
                o_rready <= 1'b0;  // read transfer on this edge
            end else if (i_rvalid) begin
                if (rdelay == 2'd0) begin
                    o_rready <= 1'b1;
                    o_rdata  <= fetch_line(i_raddr);
                    rdelay   <= 2'($unsigned($random(seed)) % 4);
                end else begin
                    rdelay <= rdelay - 2'd1;
                end
            end
            if (o_wready) begin
                o_wready <= 1'b0;
                lines[i_waddr] = i_wdata;
                if (i_waddr[5:0] != 6'd0 || i_wdata != i_wb_expect) begin
                    o_err <= 1'b1;
                end
            end else if (i_wvalid) begin
                if (wdelay == 2'd0) begin
                    o_wready <= 1'b1;
                    wdelay   <= 2'($unsigned($random(seed)) % 4);
                end else begin
                    wdelay <= wdelay - 2'd1;
                end
            end
        end
    end

endmodule

// ==== test/tb_dcache.sv ====
module tb_dcache import dcache_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] BASE    = 32'h1c00_0000;
    // about 200 requests at 12 cycles each, plus reset
    localparam int          TIMEOUT = 200 * 12 + 40;

    logic                 clk;
    logic                 rstn;
    logic                 i_valid;
    logic                 i_op;
    logic                 i_signed;
    logic [31:0]          i_addr;
    logic [31:0]          i_wdata;
    size_e                i_size;
    logic                 o_idle;
    logic                 o_done;
    logic                 o_ale;
    logic [31:0]          o_rdata;
    logic                 mem_rvalid;
    logic                 mem_rready;
    logic                 mem_wvalid;
    logic                 mem_wready;
    logic                 mem_err;
    logic [31:0]          mem_raddr;
    logic [31:0]          mem_waddr;
    logic [LINE_BITS-1:0] mem_rdata;
    logic [LINE_BITS-1:0] mem_wdata;
    line_u                wb_expect;
    logic [7:0]           shadow [1024];  // 4 tags x 4 sets x 64 bytes
    int                   cycles = 0;
    integer               seed = 32'h88fe0043;
    string                test_name;
    logic [31:0]          exp_waddr;
    logic                 check_waddr;
    logic                 wb_seen;

    dcache_top uut (
        .clk, .rstn, .i_valid, .i_op, .i_addr, .i_wdata, .i_size, .i_signed,
        .o_idle, .o_done, .o_rdata, .o_ale,
        .o_mem_rvalid(mem_rvalid), .i_mem_rready(mem_rready), .o_mem_raddr(mem_raddr),
        .i_mem_rdata(mem_rdata), .o_mem_wvalid(mem_wvalid), .i_mem_wready(mem_wready),
        .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata)
    );

    tb_mem_model u_mem (
        .clk, .rstn, .i_rvalid(mem_rvalid), .o_rready(mem_rready), .i_raddr(mem_raddr),
        .o_rdata(mem_rdata), .i_wvalid(mem_wvalid), .o_wready(mem_wready),
        .i_waddr(mem_waddr), .i_wdata(mem_wdata), .i_wb_expect(wb_expect), .o_err(mem_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] addr_of(input int t, input int i, input int off);
        return BASE | 32'(t << 12) | 32'(i << 6) | 32'(off);
    endfunction

    function automatic int slot_of(input logic [31:0] a);
        return int'({a[13:12], a[7:6], a[5:0]});
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [31:0] a);
        logic [31:0] w;
        w = {~a[31:16], a[15:2], 2'b00};
        return w[8*a[1:0] +: 8];
    endfunction

    // little endian bytes from the shadow, then extension
    function automatic logic [31:0] load_expect(input logic [31:0] a, input size_e size,
                                                input logic sgn);
        int s;
        s = slot_of(a);
        case (size)
            SZ_BYTE: return {{24{sgn & shadow[s][7]}}, shadow[s]};
            SZ_HALF: return {{16{sgn & shadow[s+1][7]}}, shadow[s+1], shadow[s]};
            default: return {shadow[s+3], shadow[s+2], shadow[s+1], shadow[s]};
        endcase
    endfunction

    task automatic store_shadow(input logic [31:0] a, input size_e size,
                                input logic [31:0] data);
        int n;
        n = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            shadow[slot_of(a) + k] = data[8*k +: 8];
        end
    endtask

    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            wb_expect.b[i] = shadow[slot_of(mem_waddr) + i];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            fail_stop($sformatf("timeout after %0d cycles in %s", cycles, test_name));
        end
    end

    always @(negedge clk) begin
        if (mem_err) begin
            fail_stop($sformatf("Error: %s writeback to %h expected %h actual %h",
                                test_name, mem_waddr, wb_expect, mem_wdata));
        end
    end

    // valid held with stable address and data until ready
    assert property (@(posedge clk) disable iff (!rstn)
        mem_rvalid && !mem_rready |=> mem_rvalid && $stable(mem_raddr))
    else fail_stop("read request dropped or changed before its transfer");

    assert property (@(posedge clk) disable iff (!rstn)
        mem_wvalid && !mem_wready |=> mem_wvalid && $stable(mem_waddr) && $stable(mem_wdata))
    else fail_stop("writeback dropped or changed before its transfer");

    // a finished request leaves no memory request behind
    assert property (@(posedge clk) disable iff (!rstn)
        o_done |=> !mem_rvalid && !mem_wvalid)
    else fail_stop("memory request raised after the request was done");

    // hit_exp 1 must hit, 0 must miss, -1 either
    task automatic access(input logic op, input logic [31:0] a, input logic [31:0] data,
                          input size_e size, input logic sgn, input int hit_exp);
        int          lat;
        int          n;
        logic        mis;
        logic [31:0] exp;
        n   = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
        mis = (a % n) != 0;  // address not a multiple of the access size
        exp = load_expect(a, size, sgn);
        @(posedge clk);
        i_valid  <= 1'b1;
        i_op     <= op;
        i_addr   <= a;
        i_wdata  <= data;
        i_size   <= size;
        i_signed <= sgn;
        @(posedge clk);  // accepted here
        i_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (mem_wvalid) wb_seen = 1'b1;
            if (mis || hit_exp == 1) begin
                assert (!mem_rvalid && !mem_wvalid)
                else fail_stop($sformatf("%s raised a memory request", test_name));
            end
            if (mem_rvalid) begin
                assert (mem_raddr == {a[31:6], 6'd0})
                else fail_stop($sformatf("Error: %s raddr expected %h actual %h",
                                         test_name, {a[31:6], 6'd0}, mem_raddr));
            end
            if (mem_wvalid && check_waddr) begin
                assert (mem_waddr == exp_waddr)
                else fail_stop($sformatf("Error: %s waddr expected %h actual %h",
                                         test_name, exp_waddr, mem_waddr));
            end
        end while (!o_done);
        assert (o_ale == mis)
        else fail_stop($sformatf("Error: %s ale expected %b actual %b", test_name, mis, o_ale));
        if (mis || hit_exp == 1) begin
            assert (lat == 1)
            else fail_stop($sformatf("Error: %s latency expected 1 actual %0d", test_name, lat));
        end
        if (hit_exp == 0) begin
            assert (lat > 1)
            else fail_stop($sformatf("%s hit on a line that should miss", test_name));
        end
        if (!op && !mis) begin
            assert (o_rdata == exp)
            else fail_stop($sformatf("Error: %s rdata expected %h actual %h",
                                     test_name, exp, o_rdata));
        end
        if (op && !mis) store_shadow(a, size, data);
    endtask

    initial begin
        int    t;
        int    idx;
        int    off;
        size_e sz;
        rstn        = 1'b0;
        i_valid     = 1'b0;
        i_op        = 1'b0;
        i_addr      = '0;
        i_wdata     = '0;
        i_size      = SZ_WORD;
        i_signed    = 1'b0;
        check_waddr = 1'b0;
        exp_waddr   = '0;
        wb_seen     = 1'b0;
        test_name   = "reset";
        for (int s = 0; s < 1024; s++) begin
            shadow[s] = pattern_byte(addr_of(s / 256, (s / 64) % 4, s % 64));
        end
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (o_idle && !o_done && !mem_rvalid && !mem_wvalid)
        else fail_stop("outputs not idle after reset");

        test_name = "load_miss";
        access(1'b0, addr_of(0, 0, 8), 32'd0, SZ_WORD, 1'b0, 0);
        test_name = "load_hit";
        access(1'b0, addr_of(0, 0, 12), 32'd0, SZ_WORD, 1'b0, 1);
        access(1'b0, addr_of(0, 0, 3), 32'd0, SZ_BYTE, 1'b1, 1);

        test_name = "store_load";
        access(1'b0, addr_of(0, 1, 0), 32'd0, SZ_WORD, 1'b0, 0);
        access(1'b1, addr_of(0, 1, 8), 32'h1234_f678, SZ_WORD, 1'b0, 1);
        access(1'b1, addr_of(0, 1, 13), 32'h0000_00a5, SZ_BYTE, 1'b0, 1);
        access(1'b1, addr_of(0, 1, 14), 32'h0000_8c31, SZ_HALF, 1'b0, 1);
        access(1'b1, addr_of(1, 2, 20), 32'hfeed_beef, SZ_WORD, 1'b0, 0);  // store miss
        access(1'b0, addr_of(1, 2, 20), 32'd0, SZ_WORD, 1'b0, 1);
        for (int sg = 0; sg < 2; sg++) begin
            for (int o = 8; o < 16; o++) begin
                access(1'b0, addr_of(0, 1, o), 32'd0, SZ_BYTE, 1'(sg), 1);
                if (o % 2 == 0) access(1'b0, addr_of(0, 1, o), 32'd0, SZ_HALF, 1'(sg), 1);
                if (o % 4 == 0) access(1'b0, addr_of(0, 1, o), 32'd0, SZ_WORD, 1'(sg), 1);
            end
        end

        test_name = "eviction";
        access(1'b1, addr_of(0, 3, 0), 32'h1111_1111, SZ_WORD, 1'b0, 0);
        access(1'b1, addr_of(1, 3, 4), 32'h2222_2222, SZ_WORD, 1'b0, 0);
        access(1'b0, addr_of(0, 3, 0), 32'd0, SZ_WORD, 1'b0, 1);  // second line now oldest
        exp_waddr   = addr_of(1, 3, 0);
        check_waddr = 1'b1;
        wb_seen     = 1'b0;
        access(1'b0, addr_of(2, 3, 8), 32'd0, SZ_WORD, 1'b0, 0);
        check_waddr = 1'b0;
        assert (wb_seen) else fail_stop("eviction of a dirty line gave no writeback");
        access(1'b0, addr_of(0, 3, 0), 32'd0, SZ_WORD, 1'b0, 1);
        access(1'b0, addr_of(2, 3, 8), 32'd0, SZ_WORD, 1'b0, 1);
        access(1'b0, addr_of(1, 3, 4), 32'd0, SZ_WORD, 1'b0, 0);  // back from memory

        test_name = "misaligned";
        access(1'b1, addr_of(0, 1, 9), 32'hdead_beef, SZ_HALF, 1'b0, -1);
        access(1'b1, addr_of(0, 1, 10), 32'hdead_beef, SZ_WORD, 1'b0, -1);
        access(1'b0, addr_of(3, 0, 3), 32'd0, SZ_WORD, 1'b0, -1);
        access(1'b0, addr_of(0, 1, 8), 32'd0, SZ_WORD, 1'b0, 1);
        access(1'b0, addr_of(0, 1, 8), 32'd0, SZ_HALF, 1'b1, 1);

        test_name = "random";
        repeat (120) begin
            t   = int'($unsigned($random(seed)) % 4);
            idx = int'($unsigned($random(seed)) % 4);
            off = int'($unsigned($random(seed)) % 64);
            sz  = size_e'($unsigned($random(seed)) % 3);
            if ($unsigned($random(seed)) % 8 != 0) begin
                off = (sz == SZ_WORD) ? off & ~3 : (sz == SZ_HALF) ? off & ~1 : off;
            end
            access(1'($random(seed)), addr_of(t, idx, off), $random(seed), sz,
                   1'($random(seed)), -1);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== dcache_top.f ====
hw/dcache_pkg.sv
hw/dcache_ifs.sv
hw/dcache_ctrl.sv
hw/dcache_req_stage.sv
hw/dcache_ways.sv
hw/dcache_mem_port.sv
hw/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
